// File: build.f
+incdir+include
verilog/ex_pkg.sv
verilog/ex_unit_if.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
tb/tb_ex_stage.sv

// File: Makefile
# Verilator flow for the execute stage testbench

TOP = tb_ex_stage

.PHONY: all lint clean

all:
	verilator --binary --timing -sv -f build.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only -Wall -sv --top-module ex_stage \
	  verilog/ex_pkg.sv verilog/ex_unit_if.sv verilog/ex_alu.sv \
	  verilog/ex_mult.sv verilog/ex_writeback.sv verilog/ex_stage.sv

clean:
	rm -rf obj_dir

// File: include/tb_ex_vectors.svh
// Vector table for the execute stage testbench
// Columns: name, kind, ALU op, mult op, a, b, c, data (CSR or load word),
// waddr, random flag, expected word (branch rows use bit 0)
// Random rows take a and b from the LFSR and compute the expected word
`ifndef TB_EX_VECTORS_SVH
`define TB_EX_VECTORS_SVH

task automatic load_vectors();
  // ALU, directed
  add_row("add", K_ALU, ALU_ADD, MUL_LO, 32'h5, 32'h7, 0, 0, 6'h01, 0, 32'h0000_000c);
  add_row("add_wrap", K_ALU, ALU_ADD, MUL_LO, 32'hffff_ffff, 32'h1, 0, 0, 6'h02, 0, 32'h0);
  add_row("sub", K_ALU, ALU_SUB, MUL_LO, 32'h3, 32'h5, 0, 0, 6'h03, 0, 32'hffff_fffe);
  add_row("xor", K_ALU, ALU_XOR, MUL_LO, 32'hf0f0_f0f0, 32'hff00_ff00, 0, 0, 6'h04, 0,
          32'h0ff0_0ff0);
  add_row("or", K_ALU, ALU_OR, MUL_LO, 32'hf0f0_f0f0, 32'h0f0f_0000, 0, 0, 6'h05, 0,
          32'hffff_f0f0);
  add_row("and", K_ALU, ALU_AND, MUL_LO, 32'hf0f0_f0f0, 32'hff00_ff00, 0, 0, 6'h06, 0,
          32'hf000_f000);
  add_row("sll", K_ALU, ALU_SLL, MUL_LO, 32'h1, 32'h1f, 0, 0, 6'h07, 0, 32'h8000_0000);
  // Only the low five bits of b shift
  add_row("sll_mask", K_ALU, ALU_SLL, MUL_LO, 32'h3, 32'h21, 0, 0, 6'h08, 0, 32'h6);
  add_row("srl", K_ALU, ALU_SRL, MUL_LO, 32'h8000_0000, 32'h4, 0, 0, 6'h09, 0, 32'h0800_0000);
  add_row("sra", K_ALU, ALU_SRA, MUL_LO, 32'h8000_0000, 32'h4, 0, 0, 6'h0a, 0, 32'hf800_0000);
  add_row("slt", K_ALU, ALU_SLT, MUL_LO, 32'hffff_ffff, 32'h1, 0, 0, 6'h0b, 0, 32'h1);
  add_row("sltu", K_ALU, ALU_SLTU, MUL_LO, 32'hffff_ffff, 32'h1, 0, 0, 6'h0c, 0, 32'h0);

  // ALU, random operands
  add_row("add_rnd", K_ALU, ALU_ADD, MUL_LO, 0, 0, 0, 0, 6'h10, 1, 0);
  add_row("sub_rnd", K_ALU, ALU_SUB, MUL_LO, 0, 0, 0, 0, 6'h11, 1, 0);
  add_row("xor_rnd", K_ALU, ALU_XOR, MUL_LO, 0, 0, 0, 0, 6'h12, 1, 0);
  add_row("sra_rnd", K_ALU, ALU_SRA, MUL_LO, 0, 0, 0, 0, 6'h13, 1, 0);
  add_row("slt_rnd", K_ALU, ALU_SLT, MUL_LO, 0, 0, 0, 0, 6'h14, 1, 0);
  add_row("sltu_rnd", K_ALU, ALU_SLTU, MUL_LO, 0, 0, 0, 0, 6'h15, 1, 0);

  // Branch compares
  add_row("beq", K_BR, ALU_EQ, MUL_LO, 32'h5, 32'h5, 32'h0000_1000, 0, 0, 0, 1);
  add_row("bne", K_BR, ALU_NE, MUL_LO, 32'h5, 32'h5, 32'h0000_2004, 0, 0, 0, 0);
  add_row("blt", K_BR, ALU_LT, MUL_LO, 32'hffff_fffe, 32'h1, 32'h0000_3008, 0, 0, 0, 1);
  add_row("bge", K_BR, ALU_GE, MUL_LO, 32'hffff_fffe, 32'h1, 32'h8000_0000, 0, 0, 0, 0);
  add_row("bltu", K_BR, ALU_LTU, MUL_LO, 32'hffff_fffe, 32'h1, 32'h0000_400c, 0, 0, 0, 0);
  add_row("bgeu", K_BR, ALU_GEU, MUL_LO, 32'hffff_fffe, 32'h1, 32'hffff_fffc, 0, 0, 0, 1);
  add_row("blt_rnd", K_BR, ALU_LT, MUL_LO, 0, 0, 32'h0000_5010, 0, 0, 1, 0);
  add_row("bgeu_rnd", K_BR, ALU_GEU, MUL_LO, 0, 0, 32'h0000_6014, 0, 0, 1, 0);

  // Multiplier, directed
  add_row("mul", K_MUL, ALU_ADD, MUL_LO, 32'h6, 32'h7, 0, 0, 6'h20, 0, 32'h2a);
  add_row("mul_neg", K_MUL, ALU_ADD, MUL_LO, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 6'h21, 0,
          32'h1);
  add_row("mulh", K_MUL, ALU_ADD, MUL_HSS, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 6'h22, 0,
          32'h0);
  add_row("mulh_min", K_MUL, ALU_ADD, MUL_HSS, 32'h8000_0000, 32'h8000_0000, 0, 0, 6'h23, 0,
          32'h4000_0000);
  add_row("mulhsu", K_MUL, ALU_ADD, MUL_HSU, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 6'h24, 0,
          32'hffff_ffff);
  add_row("mulhu", K_MUL, ALU_ADD, MUL_HUU, 32'hffff_ffff, 32'hffff_ffff, 0, 0, 6'h25, 0,
          32'hffff_fffe);

  // Multiplier, random operands
  add_row("mul_rnd", K_MUL, ALU_ADD, MUL_LO, 0, 0, 0, 0, 6'h26, 1, 0);
  add_row("mulh_rnd", K_MUL, ALU_ADD, MUL_HSS, 0, 0, 0, 0, 6'h27, 1, 0);
  add_row("mulhsu_rnd", K_MUL, ALU_ADD, MUL_HSU, 0, 0, 0, 0, 6'h28, 1, 0);
  add_row("mulhu_rnd", K_MUL, ALU_ADD, MUL_HUU, 0, 0, 0, 0, 6'h29, 1, 0);

  // CSR priority over ALU and multiplier
  add_row("csr", K_CSR, ALU_ADD, MUL_LO, 32'h3, 32'h4, 0, 32'hdead_beef, 6'h30, 0,
          32'hdead_beef);
  add_row("csr_rnd_ops", K_CSR, ALU_OR, MUL_LO, 32'h0, 32'h0, 0, 32'h0bad_f00d, 6'h31, 0,
          32'h0bad_f00d);

  // LSU port and back-pressure
  add_row("lsu", K_LSU, ALU_ADD, MUL_LO, 0, 0, 0, 32'h1234_5678, 6'h15, 0, 0);
  add_row("backpressure", K_BP, ALU_ADD, MUL_LO, 0, 0, 0, 32'hcafe_f00d, 6'h2a, 0, 0);
endtask

`endif

// File: tb/tb_ex_stage.sv
// Testbench for the integer execute stage
// Applies the vector table from the include folder row by row and checks
// forwarding data, branch outputs, multiplier stalls, LSU port and back-pressure
`timescale 1ns/1ps

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int MULH_CYCLES = 3;
  localparam int CLK_PERIOD  = 20;

  // Row kinds, one per behavior under test
  typedef enum {K_ALU, K_BR, K_MUL, K_CSR, K_LSU, K_BP} kind_t;

  typedef struct {
    string     name;
    kind_t     kind;
    alu_op_t   alu_op;
    mult_op_t  mult_op;
    word_t     a;
    word_t     b;
    word_t     c;
    word_t     data;
    reg_addr_t waddr;
    bit        rnd;
    word_t     exp;
  } vec_t;

  logic      clk;
  logic      rst_n;
  alu_op_t   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  word_t     alu_operand_c_i;
  logic      alu_en_i;
  mult_op_t  mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  logic      mult_en_i;
  logic      mult_multicycle_o;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      branch_in_ex_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_alu_we_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  reg_addr_t regfile_waddr_wb_o;
  logic      regfile_we_wb_o;
  word_t     regfile_wdata_wb_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  logic      regfile_alu_we_fw_o;
  word_t     regfile_alu_wdata_fw_o;
  word_t     jump_target_o;
  logic      branch_decision_o;
  logic      ex_ready_o;
  logic      ex_valid_o;
  logic      wb_ready_i;

  vec_t      vecs[$];
  logic [31:0] lfsr;

  ex_stage #(
    .MULH_CYCLES (MULH_CYCLES)
  ) ex_stage_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_operator_i         (alu_operator_i),
    .alu_operand_a_i        (alu_operand_a_i),
    .alu_operand_b_i        (alu_operand_b_i),
    .alu_operand_c_i        (alu_operand_c_i),
    .alu_en_i               (alu_en_i),
    .mult_operator_i        (mult_operator_i),
    .mult_operand_a_i       (mult_operand_a_i),
    .mult_operand_b_i       (mult_operand_b_i),
    .mult_en_i              (mult_en_i),
    .mult_multicycle_o      (mult_multicycle_o),
    .lsu_en_i               (lsu_en_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .csr_access_i           (csr_access_i),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .jump_target_o          (jump_target_o),
    .branch_decision_o      (branch_decision_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o),
    .wb_ready_i             (wb_ready_i)
  );

  ////////////////////
  // Clock
  ////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Finished with errors");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("Finished with errors");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      $display("Finished with errors");
      $fatal(1, "flag mismatch");
    end
  endtask

  ////////////////////
  // Random source
  ////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic word_t lfsr_word();
    word_t w;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT,
      ALU_LT:   return word_t'($signed(a) < $signed(b));
      ALU_SLTU,
      ALU_LTU:  return word_t'(a < b);
      ALU_EQ:   return word_t'(a == b);
      ALU_NE:   return word_t'(a != b);
      ALU_GE:   return word_t'($signed(a) >= $signed(b));
      default:  return word_t'(a >= b);
    endcase
  endfunction

  // 64-bit product, exact for every signedness mix
  function automatic word_t ref_mul(input mult_op_t op, input word_t a, input word_t b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] p;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (op)
      MUL_LO:  p = ua * ub;
      MUL_HSS: p = sa * sb;
      MUL_HSU: p = sa * ub;
      default: p = ua * ub;
    endcase
    return (op == MUL_LO) ? p[31:0] : p[63:32];
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_idle();
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = MUL_LO;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    branch_in_ex_i      = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    wb_ready_i          = 1'b1;
  endtask

  task automatic add_row(input string name, input kind_t kind, input alu_op_t aop,
                         input mult_op_t mop, input word_t a, input word_t b,
                         input word_t c, input word_t data, input reg_addr_t waddr,
                         input bit rnd, input word_t exp);
    vec_t v;
    v.name    = name;
    v.kind    = kind;
    v.alu_op  = aop;
    v.mult_op = mop;
    v.a       = a;
    v.b       = b;
    v.c       = c;
    v.data    = data;
    v.waddr   = waddr;
    v.rnd     = rnd;
    v.exp     = exp;
    vecs.push_back(v);
  endtask

`include "tb_ex_vectors.svh"

  // Load a word to the EX/WB register, then see it on the LSU port
  // WB readiness in the write-back cycle decides whether the entry drains next
  task automatic load_lsu(input vec_t v, input logic wb_ready);
    @(negedge clk);
    drive_idle();
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = v.waddr;
    #1;
    check_bit({v.name, " valid"}, 1'b1, ex_valid_o);
    @(negedge clk);
    drive_idle();
    wb_ready_i  = wb_ready;
    lsu_rdata_i = v.data;
    #1;
    check_bit({v.name, " we_wb"}, 1'b1, regfile_we_wb_o);
    check_addr({v.name, " waddr_wb"}, v.waddr, regfile_waddr_wb_o);
    check_word({v.name, " wdata_wb"}, v.data, regfile_wdata_wb_o);
  endtask

  task automatic run_row(input vec_t v);
    word_t a;
    word_t b;
    word_t exp;
    int    stall;
    a   = v.a;
    b   = v.b;
    exp = v.exp;
    if (v.rnd) begin
      a   = lfsr_word();
      b   = lfsr_word();
      exp = (v.kind == K_MUL) ? ref_mul(v.mult_op, a, b) : ref_alu(v.alu_op, a, b);
    end
    case (v.kind)
      K_ALU, K_BR, K_CSR: begin
        @(negedge clk);
        drive_idle();
        alu_en_i            = 1'b1;
        alu_operator_i      = v.alu_op;
        alu_operand_a_i     = a;
        alu_operand_b_i     = b;
        alu_operand_c_i     = v.c;
        regfile_alu_we_i    = (v.kind != K_BR);
        regfile_alu_waddr_i = v.waddr;
        branch_in_ex_i      = (v.kind == K_BR);
        if (v.kind == K_CSR) begin
          // Multiplier also enabled, CSR data must still win
          csr_access_i     = 1'b1;
          csr_rdata_i      = v.data;
          mult_en_i        = 1'b1;
          mult_operand_a_i = a;
          mult_operand_b_i = b;
        end
        #1;
        // Branches carry no register write
        check_bit({v.name, " fw we"}, v.kind != K_BR, regfile_alu_we_fw_o);
        if (v.kind == K_BR) begin
          check_bit({v.name, " branch"}, exp[0], branch_decision_o);
          check_word({v.name, " jump"}, v.c, jump_target_o);
        end else begin
          check_word({v.name, " fw data"}, exp, regfile_alu_wdata_fw_o);
          check_addr({v.name, " fw addr"}, v.waddr, regfile_alu_waddr_fw_o);
          check_bit({v.name, " valid"}, 1'b1, ex_valid_o);
        end
      end
      K_MUL: begin
        @(negedge clk);
        drive_idle();
        mult_en_i           = 1'b1;
        mult_operator_i     = v.mult_op;
        mult_operand_a_i    = a;
        mult_operand_b_i    = b;
        regfile_alu_we_i    = 1'b1;
        regfile_alu_waddr_i = v.waddr;
        #1;
        stall = 0;
        while (!ex_ready_o) begin
          check_bit({v.name, " multicycle"}, 1'b1, mult_multicycle_o);
          stall++;
          @(negedge clk);
          #1;
        end
        if (v.mult_op != MUL_LO) begin
          check_word({v.name, " stall cycles"}, word_t'(MULH_CYCLES - 1), word_t'(stall));
        end else begin
          check_word({v.name, " stall cycles"}, '0, word_t'(stall));
        end
        check_bit({v.name, " multicycle done"}, 1'b0, mult_multicycle_o);
        check_word({v.name, " fw data"}, exp, regfile_alu_wdata_fw_o);
      end
      K_LSU: begin
        load_lsu(v, 1'b1);
        @(negedge clk);
        drive_idle();
        #1;
        check_bit({v.name, " we_wb drained"}, 1'b0, regfile_we_wb_o);
      end
      default: begin
        load_lsu(v, 1'b0);
        // WB stalls, a new load must not enter
        for (int i = 0; i < 2; i++) begin
          @(negedge clk);
          drive_idle();
          wb_ready_i      = 1'b0;
          lsu_en_i        = 1'b1;
          lsu_rdata_i     = v.data;
          regfile_we_i    = 1'b1;
          regfile_waddr_i = v.waddr + 6'd1;
          #1;
          check_bit({v.name, " ready"}, 1'b0, ex_ready_o);
          check_bit({v.name, " valid"}, 1'b0, ex_valid_o);
          check_bit({v.name, " we_wb held"}, 1'b1, regfile_we_wb_o);
          check_addr({v.name, " waddr held"}, v.waddr, regfile_waddr_wb_o);
          check_word({v.name, " wdata held"}, v.data, regfile_wdata_wb_o);
        end
        @(negedge clk);
        drive_idle();
        wb_ready_i     = 1'b0;
        lsu_en_i       = 1'b1;
        branch_in_ex_i = 1'b1;
        #1;
        check_bit({v.name, " branch ready"}, 1'b1, ex_ready_o);
        check_bit({v.name, " branch valid"}, 1'b0, ex_valid_o);
      end
    endcase
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    #1;
    #((vecs.size() * (MULH_CYCLES + 4) + 4 + 10) * CLK_PERIOD);
    $display("Timeout: the run did not finish in the expected time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    load_vectors();
    lfsr  = 32'hb014;
    rst_n = 1'b0;
    drive_idle();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_bit("reset we_wb", 1'b0, regfile_we_wb_o);
    check_bit("reset multicycle", 1'b0, mult_multicycle_o);
    check_bit("reset ready", 1'b1, ex_ready_o);
    foreach (vecs[i]) begin
      run_row(vecs[i]);
    end
    @(negedge clk);
    drive_idle();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: verilog/ex_stage.sv
// Top level of the integer execute stage
// Hosts the ALU, the multiplier and the write-back ports, and produces the
// branch outputs and the ready/valid stall handshake toward ID and WB
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
#(
  parameter int MULH_CYCLES = 3
) (
  input  logic      clk,
  input  logic      rst_n,

  // ALU request from ID
  input  alu_op_t   alu_operator_i,
  input  word_t     alu_operand_a_i,
  input  word_t     alu_operand_b_i,
  input  word_t     alu_operand_c_i,
  input  logic      alu_en_i,

  // Multiplier request from ID
  input  mult_op_t  mult_operator_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,
  input  logic      mult_en_i,
  output logic      mult_multicycle_o,

  // LSU side
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,

  input  logic      branch_in_ex_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_alu_we_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,

  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // Write ports
  output reg_addr_t regfile_waddr_wb_o,
  output logic      regfile_we_wb_o,
  output word_t     regfile_wdata_wb_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output logic      regfile_alu_we_fw_o,
  output word_t     regfile_alu_wdata_fw_o,

  // Branch outputs toward IF
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  // Stall handshake
  output logic      ex_ready_o,
  output logic      ex_valid_o,
  input  logic      wb_ready_i
);

  logic alu_cmp_result;
  logic mult_ready;
  logic units_ready;

  ex_unit_if #(.op_t(alu_op_t))  alu_bus ();
  ex_unit_if #(.op_t(mult_op_t)) mult_bus ();

  ////////////////////
  // Unit requests
  ////////////////////

  assign alu_bus.en         = alu_en_i;
  assign alu_bus.op         = alu_operator_i;
  assign alu_bus.operand_a  = alu_operand_a_i;
  assign alu_bus.operand_b  = alu_operand_b_i;

  assign mult_bus.en        = mult_en_i;
  assign mult_bus.op        = mult_operator_i;
  assign mult_bus.operand_a = mult_operand_a_i;
  assign mult_bus.operand_b = mult_operand_b_i;

  ex_alu alu_i (
    .bus_i        (alu_bus),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult #(
    .MULH_CYCLES (MULH_CYCLES)
  ) mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_i        (mult_bus),
    .ex_ready_i   (ex_ready_o),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback writeback_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_result_i           (alu_bus.result),
    .mult_result_i          (mult_bus.result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_we_i           (regfile_we_i),
    .ex_valid_i             (ex_valid_o),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o)
  );

  ////////////////////
  // Branch and handshake
  ////////////////////

  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve in EX without a WB slot, so they never stall
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid flows forward and does not wait on ex_ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

// File: verilog/ex_writeback.sv
// Register-file write ports of the execute stage
// The forwarding port picks CSR, multiplier or ALU data in this cycle
// The LSU port writes load data through the EX/WB register one cycle later
`timescale 1ns/1ps

module ex_writeback
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  word_t     lsu_rdata_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,

  input  reg_addr_t regfile_alu_waddr_i,
  input  reg_addr_t regfile_waddr_i,
  input  logic      regfile_alu_we_i,
  input  logic      regfile_we_i,

  input  logic      ex_valid_i,
  input  logic      wb_ready_i,

  output reg_addr_t regfile_alu_waddr_fw_o,
  output logic      regfile_alu_we_fw_o,
  output word_t     regfile_alu_wdata_fw_o,

  output reg_addr_t regfile_waddr_wb_o,
  output logic      regfile_we_wb_o,
  output word_t     regfile_wdata_wb_o
);

  logic      regfile_we_lsu;
  reg_addr_t regfile_waddr_lsu;

  ////////////////////
  // Forwarding port
  ////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over the multiplier, the multiplier over the ALU
  always_comb begin
    regfile_alu_wdata_fw_o = alu_result_i;
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end
  end

  ////////////////////
  // EX/WB register
  ////////////////////

  // A valid cycle loads the load write enable
  // An empty cycle with WB ready drains it, otherwise it holds
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu <= 1'b0;
    end else if (ex_valid_i) begin
      regfile_we_lsu <= regfile_we_i;
    end else if (wb_ready_i) begin
      regfile_we_lsu <= 1'b0;
    end
  end

  // Destination only changes when a load write is captured
  always_ff @(posedge clk) begin
    if (ex_valid_i && regfile_we_i) begin
      regfile_waddr_lsu <= regfile_waddr_i;
    end
  end

  // LSU port, data arrives from memory in the write-back cycle
  assign regfile_we_wb_o    = regfile_we_lsu;
  assign regfile_waddr_wb_o = regfile_waddr_lsu;
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: verilog/ex_mult.sv
// Integer multiplier for the execute stage
// MUL_LO returns the low product in the same cycle
// High-half products stall for MULH_CYCLES-1 cycles, then present the high word
// until the stage accepts it through ex_ready_i
`timescale 1ns/1ps

module ex_mult
  import ex_pkg::*;
#(
  parameter int MULH_CYCLES = 3
) (
  input  logic    clk,
  input  logic    rst_n,
  ex_unit_if.unit bus_i,
  input  logic    ex_ready_i,
  output logic    ready_o,
  output logic    multicycle_o
);

  localparam int CNT_W = $clog2(MULH_CYCLES + 1);

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_RUN,
    MS_DONE
  } mult_state_t;

  mult_state_t        state_q;
  mult_state_t        state_d;
  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   cnt_d;

  logic               is_high;
  logic               sign_a;
  logic               sign_b;
  logic signed [32:0] a_ext;
  logic signed [32:0] b_ext;
  logic signed [63:0] prod_full;
  logic        [63:0] prod_q;
  logic               load_prod;

  ////////////////////
  // Operand extension
  ////////////////////

  assign is_high = (bus_i.op != MUL_LO);
  // HSS and HSU treat a as signed, only HSS treats b as signed
  assign sign_a  = (bus_i.op == MUL_HSS) || (bus_i.op == MUL_HSU);
  assign sign_b  = (bus_i.op == MUL_HSS);

  assign a_ext = {sign_a & bus_i.operand_a[31], bus_i.operand_a};
  assign b_ext = {sign_b & bus_i.operand_b[31], bus_i.operand_b};

  // One 33x33 signed multiplier serves all four operators
  assign prod_full = a_ext * b_ext;

  ////////////////////
  // Sequencing FSM
  ////////////////////

  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    load_prod    = 1'b0;
    case (state_q)
      MS_IDLE: begin
        if (bus_i.en && is_high) begin
          // First cycle of a high product already stalls
          ready_o      = 1'b0;
          multicycle_o = 1'b1;
          load_prod    = 1'b1;
          if (MULH_CYCLES == 2) begin
            state_d = MS_DONE;
          end else begin
            state_d = MS_RUN;
            cnt_d   = CNT_W'(2);
          end
        end
      end
      MS_RUN: begin
        ready_o      = 1'b0;
        multicycle_o = 1'b1;
        if (cnt_q == CNT_W'(MULH_CYCLES - 1)) begin
          state_d = MS_DONE;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      // Hold the high word until the stage moves on
      MS_DONE: begin
        if (ex_ready_i) begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Product register, captured in the first cycle
  always_ff @(posedge clk) begin
    if (load_prod) begin
      prod_q <= prod_full;
    end
  end

  assign bus_i.result = (state_q == MS_DONE) ? prod_q[63:32] : prod_full[31:0];

endmodule

// File: verilog/ex_alu.sv
// Combinational integer ALU for the execute stage
// Computes add/sub, logic, shifts, set-less-than and the branch compares
// The compare flag feeds the branch decision in the stage
`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  ex_unit_if.unit bus_i,
  output logic    cmp_result_o
);

  word_t              op_a;
  word_t              op_b;
  logic [SHAMT_W-1:0] shamt;

  word_t              sum;
  word_t              diff;
  word_t              shl;
  word_t              shr_log;
  word_t              shr_ari;

  logic               is_eq;
  logic               lt_s;
  logic               lt_u;

  assign op_a  = bus_i.operand_a;
  assign op_b  = bus_i.operand_b;

  // Only the low bits of b count as shift amount
  assign shamt = op_b[SHAMT_W-1:0];

  ////////////////////
  // Datapath
  ////////////////////

  assign sum     = op_a + op_b;
  assign diff    = op_a - op_b;
  assign shl     = op_a << shamt;
  assign shr_log = op_a >> shamt;
  // Arithmetic right shift keeps the sign bit
  assign shr_ari = word_t'($signed(op_a) >>> shamt);

  // Shared comparators for SLT and the branch compares
  assign is_eq = (op_a == op_b);
  assign lt_s  = ($signed(op_a) < $signed(op_b));
  assign lt_u  = (op_a < op_b);

  ////////////////////
  // Comparison flag
  ////////////////////

  always_comb begin
    cmp_result_o = 1'b0;
    case (bus_i.op)
      ALU_EQ:            cmp_result_o = is_eq;
      ALU_NE:            cmp_result_o = ~is_eq;
      ALU_SLT, ALU_LT:   cmp_result_o = lt_s;
      ALU_GE:            cmp_result_o = ~lt_s;
      ALU_SLTU, ALU_LTU: cmp_result_o = lt_u;
      ALU_GEU:           cmp_result_o = ~lt_u;
      // Arithmetic and logic ops leave the flag low
      default:           cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    bus_i.result = '0;
    case (bus_i.op)
      ALU_ADD: bus_i.result = sum;
      ALU_SUB: bus_i.result = diff;
      ALU_XOR: bus_i.result = op_a ^ op_b;
      ALU_OR:  bus_i.result = op_a | op_b;
      ALU_AND: bus_i.result = op_a & op_b;
      ALU_SLL: bus_i.result = shl;
      ALU_SRL: bus_i.result = shr_log;
      ALU_SRA: bus_i.result = shr_ari;
      // Set-less-than and compares return the flag as a 0/1 word
      ALU_SLT, ALU_SLTU,
      ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU: begin
        bus_i.result = {31'b0, cmp_result_o};
      end
      default: bus_i.result = sum;
    endcase
  end

endmodule

// File: verilog/ex_unit_if.sv
// Operand and result bundle between the execute stage and one functional unit
// The operator type is a parameter so ALU and multiplier share this definition
`timescale 1ns/1ps

interface ex_unit_if
  import ex_pkg::*;
#(
  parameter type op_t = logic
) ();

  // Unit enable and operator, from the stage
  logic  en;
  op_t   op;

  // Operands and the unit's result word
  word_t operand_a;
  word_t operand_b;
  word_t result;

  // Stage side drives the request and samples the result
  modport stage (
    output en, op, operand_a, operand_b,
    input  result
  );

  // Unit side sees the request and returns the result
  modport unit (
    input  en, op, operand_a, operand_b,
    output result
  );

endinterface

// File: verilog/ex_pkg.sv
// Shared types and operator encodings for the integer execute stage
// Imported by the stage, its functional units and the unit interface
package ex_pkg;

  ////////////////////
  // Basic types
  ////////////////////

  // Data word for operands, results and register write data
  typedef logic [31:0] word_t;

  // Register-file address, 6 bits to cover the extended file
  typedef logic [5:0] reg_addr_t;

  // Shift amount width, taken from the low bits of operand b
  localparam int unsigned SHAMT_W = 5;

  ////////////////////
  // ALU operators
  ////////////////////

  // Arithmetic, logic and shifts first, then the set-less-than pair
  // The last six are the branch compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_XOR  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_AND  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_t;

  ////////////////////
  // Multiplier operators
  ////////////////////

  // MUL_LO is single cycle, the high-half products are multicycle
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HUU = 2'd3
  } mult_op_t;

endpackage
